/* verilog/noncomp_slice_pkg.sv */
package noncomp_slice_pkg;

  // Slice geometry, fixed by the FP32 / FP16x2 lane layout
  localparam int unsigned WIDTH     = 32;
  localparam int unsigned NUM_LANES = 2;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } nc_op_e;

  typedef enum logic {
    BEFORE = 1'b0,
    AFTER  = 1'b1
  } pipe_config_e;

  // IEEE exception flags, only NV can be raised here
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef logic [3:0] tag_t;

  localparam logic [31:0] CANON_NAN32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7E00;

  // Request after slicing, lane 1 only ever holds an FP16 half
  typedef struct packed {
    logic [WIDTH-1:0]     a0;
    logic [WIDTH-1:0]     b0;
    logic [WIDTH/2-1:0]   a1;
    logic [WIDTH/2-1:0]   b1;
    nc_op_e               op;
    fp_fmt_e              fmt;
    logic                 vectorial;
    logic [NUM_LANES-1:0] mask;
    tag_t                 tag;
  } slice_req_t;

  typedef struct packed {
    logic [WIDTH-1:0]              res0;
    logic [WIDTH/2-1:0]            res1;
    status_t [NUM_LANES-1:0]       status;
    fp_fmt_e                       fmt;
    logic                          vectorial;
    logic [NUM_LANES-1:0]          mask;
    tag_t                          tag;
  } slice_rsp_t;

endpackage

/* verilog/operand_slicer.sv */
module operand_slicer (
  input  logic [noncomp_slice_pkg::WIDTH-1:0]     operand_a_i,
  input  logic [noncomp_slice_pkg::WIDTH-1:0]     operand_b_i,
  input  noncomp_slice_pkg::nc_op_e               op_i,
  input  noncomp_slice_pkg::fp_fmt_e              fmt_i,
  input  logic                                    vectorial_i,
  input  logic [noncomp_slice_pkg::NUM_LANES-1:0] simd_mask_i,
  input  noncomp_slice_pkg::tag_t                 tag_i,
  output noncomp_slice_pkg::slice_req_t           req_o
);

  import noncomp_slice_pkg::*;

  localparam int unsigned HALF = WIDTH / 2;

  logic is_fp16;
  logic vectorial;

  assign is_fp16 = (fmt_i == FP16);

  // Vector mode exists only for FP16, an FP32 vector request runs scalar
  assign vectorial = vectorial_i & is_fp16;

  // ----------------------------------------
  // Lane operands
  // ----------------------------------------
  always_comb begin : place_operands
    if (is_fp16) begin
      // Low half goes to lane 0, boxed like a scalar FP16 register value
      req_o.a0 = {{HALF{1'b1}}, operand_a_i[HALF-1:0]};
      req_o.b0 = {{HALF{1'b1}}, operand_b_i[HALF-1:0]};
    end else begin
      req_o.a0 = operand_a_i;
      req_o.b0 = operand_b_i;
    end
    // Upper lane always sees the high half
    req_o.a1 = operand_a_i[WIDTH-1:HALF];
    req_o.b1 = operand_b_i[WIDTH-1:HALF];
  end

  // ----------------------------------------
  // Aux data travelling with the item
  // ----------------------------------------
  always_comb begin : build_aux
    req_o.op        = op_i;
    req_o.fmt       = fmt_i;
    req_o.vectorial = vectorial;
    req_o.tag       = tag_i;
    // Upper lane never reports status for a scalar operation
    req_o.mask      = {simd_mask_i[1] & vectorial, simd_mask_i[0]};
  end

endmodule

/* verilog/pipe_chain.sv */
module pipe_chain #(
  parameter type         payload_t = logic,
  parameter int unsigned NumRegs   = 0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o,
  output logic     busy_o
);

  // Index i holds the item after i register stages
  payload_t           stage_data [0:NumRegs];
  logic [NumRegs:0]   stage_valid;
  logic [NumRegs:0]   stage_ready;

  assign stage_data[0]  = in_data_i;
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic     valid_q;
    payload_t data_q;
    logic     load;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    // Payload only, no reset needed
    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  // Ready enters from the downstream side
  assign stage_ready[NumRegs] = out_ready_i;

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = stage_valid[NumRegs];
  assign out_data_o  = stage_data[NumRegs];

  if (NumRegs > 0) begin : gen_busy
    assign busy_o = |stage_valid[NumRegs:1];
  end else begin : gen_no_busy
    // Nothing can be held in a combinational chain
    assign busy_o = 1'b0;
  end

endmodule

/* verilog/noncomp_lane.sv */
module noncomp_lane #(
  parameter bit Fp32Lane = 1'b1
) (
  input  logic [noncomp_slice_pkg::WIDTH-1:0] a_i,
  input  logic [noncomp_slice_pkg::WIDTH-1:0] b_i,
  input  noncomp_slice_pkg::nc_op_e           op_i,
  input  noncomp_slice_pkg::fp_fmt_e          fmt_i,
  output logic [noncomp_slice_pkg::WIDTH-1:0] result_o,
  output noncomp_slice_pkg::status_t          status_o
);

  import noncomp_slice_pkg::*;

  localparam int unsigned HALF = WIDTH / 2;

  logic             use16;
  logic             sign_a;
  logic             sign_b;
  logic [WIDTH-2:0] mag_a;
  logic [WIDTH-2:0] mag_b;
  logic             nan_a;
  logic             nan_b;
  logic             snan_a;
  logic             snan_b;
  logic [WIDTH-1:0] boxed_a;
  logic [WIDTH-1:0] boxed_b;
  logic [WIDTH-1:0] canon_nan;
  logic             a_lt_b;
  logic             inj_sign;
  logic [WIDTH-1:0] inj_result;

  // A lane without FP32 support folds this to a constant
  assign use16 = !Fp32Lane || (fmt_i == FP16);

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  always_comb begin : classify
    if (use16) begin
      sign_a    = a_i[15];
      sign_b    = b_i[15];
      mag_a     = {{HALF{1'b0}}, a_i[14:0]};
      mag_b     = {{HALF{1'b0}}, b_i[14:0]};
      // Exponent 14:10, quiet bit 9
      nan_a     = (&a_i[14:10]) && (|a_i[9:0]);
      nan_b     = (&b_i[14:10]) && (|b_i[9:0]);
      snan_a    = nan_a && !a_i[9];
      snan_b    = nan_b && !b_i[9];
      boxed_a   = {{HALF{1'b1}}, a_i[HALF-1:0]};
      boxed_b   = {{HALF{1'b1}}, b_i[HALF-1:0]};
      canon_nan = {{HALF{1'b1}}, CANON_NAN16};
    end else begin
      sign_a    = a_i[31];
      sign_b    = b_i[31];
      mag_a     = a_i[30:0];
      mag_b     = b_i[30:0];
      // Exponent 30:23, quiet bit 22
      nan_a     = (&a_i[30:23]) && (|a_i[22:0]);
      nan_b     = (&b_i[30:23]) && (|b_i[22:0]);
      snan_a    = nan_a && !a_i[22];
      snan_b    = nan_b && !b_i[22];
      boxed_a   = a_i;
      boxed_b   = b_i;
      canon_nan = CANON_NAN32;
    end
  end

  // Sign-magnitude order, so -0 sorts below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // Sign injection keeps the magnitude of a
  always_comb begin : sign_inject
    case (op_i)
      SGNJ:    inj_sign = sign_b;
      SGNJN:   inj_sign = ~sign_b;
      SGNJX:   inj_sign = sign_a ^ sign_b;
      default: inj_sign = sign_a;
    endcase
    if (use16) begin
      inj_result = {{HALF{1'b1}}, inj_sign, a_i[14:0]};
    end else begin
      inj_result = {inj_sign, a_i[30:0]};
    end
  end

  // ----------------------------------------
  // Result select
  // ----------------------------------------
  always_comb begin : select_result
    result_o = boxed_a;
    status_o = '0;
    case (op_i)
      SGNJ, SGNJN, SGNJX: begin
        result_o = inj_result;
      end
      MIN, MAX: begin
        status_o.NV = snan_a || snan_b;
        if (nan_a && nan_b) begin
          result_o = canon_nan;
        end else if (nan_a) begin
          result_o = boxed_b;
        end else if (nan_b) begin
          result_o = boxed_a;
        end else if (a_lt_b == (op_i == MIN)) begin
          result_o = boxed_a;
        end else begin
          result_o = boxed_b;
        end
      end
      default: begin
        result_o = boxed_a;
      end
    endcase
  end

endmodule

/* verilog/result_packer.sv */
module result_packer (
  input  noncomp_slice_pkg::slice_rsp_t       rsp_i,
  output logic [noncomp_slice_pkg::WIDTH-1:0] result_o,
  output noncomp_slice_pkg::status_t          status_o,
  output noncomp_slice_pkg::tag_t             tag_o
);

  import noncomp_slice_pkg::*;

  localparam int unsigned HALF = WIDTH / 2;

  // ----------------------------------------
  // Result word
  // ----------------------------------------
  always_comb begin : pack_result
    if (rsp_i.fmt == FP32) begin
      result_o = rsp_i.res0;
    end else if (rsp_i.vectorial) begin
      // Lane 1 in the upper half
      result_o = {rsp_i.res1, rsp_i.res0[HALF-1:0]};
    end else begin
      // Scalar FP16 gets NaN-boxed
      result_o = {{HALF{1'b1}}, rsp_i.res0[HALF-1:0]};
    end
  end

  // ----------------------------------------
  // Status collapse
  // ----------------------------------------
  always_comb begin : collapse_status
    status_t acc;
    acc = '0;
    for (int i = 0; i < int'(NUM_LANES); i++) begin
      // Masked lanes still compute but stay silent
      acc = acc | (rsp_i.status[i] & {5{rsp_i.mask[i]}});
    end
    status_o = acc;
  end

  assign tag_o = rsp_i.tag;

endmodule

/* verilog/noncomp_slice.sv */
module noncomp_slice #(
  parameter int unsigned                     NumPipeRegs = 2,
  parameter noncomp_slice_pkg::pipe_config_e PipeConfig  = noncomp_slice_pkg::BEFORE
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Input side
  input  logic [noncomp_slice_pkg::WIDTH-1:0]     operand_a_i,
  input  logic [noncomp_slice_pkg::WIDTH-1:0]     operand_b_i,
  input  noncomp_slice_pkg::nc_op_e               op_i,
  input  noncomp_slice_pkg::fp_fmt_e              fmt_i,
  input  logic                                    vectorial_i,
  input  logic [noncomp_slice_pkg::NUM_LANES-1:0] simd_mask_i,
  input  noncomp_slice_pkg::tag_t                 tag_i,
  input  logic                                    in_valid_i,
  output logic                                    in_ready_o,
  input  logic                                    flush_i,
  // Output side
  output logic [noncomp_slice_pkg::WIDTH-1:0]     result_o,
  output noncomp_slice_pkg::status_t              status_o,
  output noncomp_slice_pkg::tag_t                 tag_o,
  output logic                                    out_valid_o,
  input  logic                                    out_ready_i,
  output logic                                    busy_o
);

  import noncomp_slice_pkg::*;

  // All registers land on one side of the lanes
  localparam int unsigned REGS_BEFORE = (PipeConfig == BEFORE) ? NumPipeRegs : 0;
  localparam int unsigned REGS_AFTER  = NumPipeRegs - REGS_BEFORE;
  localparam int unsigned HALF        = WIDTH / 2;

  slice_req_t req_d;
  slice_req_t req_q;
  slice_rsp_t rsp_d;
  slice_rsp_t rsp_q;

  logic lane_valid;
  logic lane_ready;
  logic busy_before;
  logic busy_after;

  logic [NUM_LANES-1:0][WIDTH-1:0] lane_result;
  status_t [NUM_LANES-1:0]         lane_status;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  operand_slicer i_operand_slicer (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .vectorial_i (vectorial_i),
    .simd_mask_i (simd_mask_i),
    .tag_i       (tag_i),
    .req_o       (req_d)
  );

  pipe_chain #(
    .payload_t (slice_req_t),
    .NumRegs   (REGS_BEFORE)
  ) i_pipe_before (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (req_d),
    .out_valid_o (lane_valid),
    .out_ready_i (lane_ready),
    .out_data_o  (req_q),
    .busy_o      (busy_before)
  );

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  noncomp_lane #(.Fp32Lane(1'b1)) i_lane0 (
    .a_i      (req_q.a0),
    .b_i      (req_q.b0),
    .op_i     (req_q.op),
    .fmt_i    (req_q.fmt),
    .result_o (lane_result[0]),
    .status_o (lane_status[0])
  );

  // Upper lane is FP16 only
  noncomp_lane #(.Fp32Lane(1'b0)) i_lane1 (
    .a_i      ({{HALF{1'b1}}, req_q.a1}),
    .b_i      ({{HALF{1'b1}}, req_q.b1}),
    .op_i     (req_q.op),
    .fmt_i    (req_q.fmt),
    .result_o (lane_result[1]),
    .status_o (lane_status[1])
  );

  always_comb begin : assemble_rsp
    rsp_d.res0      = lane_result[0];
    rsp_d.res1      = lane_result[1][HALF-1:0];
    rsp_d.status    = lane_status;
    rsp_d.fmt       = req_q.fmt;
    rsp_d.vectorial = req_q.vectorial;
    rsp_d.mask      = req_q.mask;
    rsp_d.tag       = req_q.tag;
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  pipe_chain #(
    .payload_t (slice_rsp_t),
    .NumRegs   (REGS_AFTER)
  ) i_pipe_after (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (lane_valid),
    .in_ready_o  (lane_ready),
    .in_data_i   (rsp_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (rsp_q),
    .busy_o      (busy_after)
  );

  result_packer i_result_packer (
    .rsp_i    (rsp_q),
    .result_o (result_o),
    .status_o (status_o),
    .tag_o    (tag_o)
  );

  assign busy_o = busy_before | busy_after;

endmodule

/* verif/noncomp_slice_asserts.sv */
module noncomp_slice_asserts #(
  parameter int unsigned NumPipeRegs = 2
) (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input logic                                flush_i,
  input logic                                out_valid_o,
  input logic                                out_ready_i,
  input logic                                busy_o,
  input logic [noncomp_slice_pkg::WIDTH-1:0] result_o,
  input noncomp_slice_pkg::tag_t             tag_o
);

  // A stalled output keeps valid and payload until it transfers or is flushed
  hold_while_stalled: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i
      |=> out_valid_o && $stable(result_o) && $stable(tag_o)
  ) else $error("Output valid or payload changed while stalled");

  if (NumPipeRegs > 0) begin : gen_reg_checks
    empty_after_reset: assert property (
      @(posedge clk_i) !rst_n_i |=> !out_valid_o
    ) else $error("Output valid high in the cycle after reset");

    // An output item must sit in some stage
    valid_needs_busy: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !busy_o |-> !out_valid_o
    ) else $error("Output valid high while the pipeline reports idle");
  end

endmodule

bind noncomp_slice noncomp_slice_asserts #(.NumPipeRegs(NumPipeRegs)) i_asserts (.*);

/* verif/noncomp_vectors.svh */
`ifndef NONCOMP_VECTORS_SVH
`define NONCOMP_VECTORS_SVH

// Each row holds name, op, fmt, vectorial, mask, a, b, expected result and expected status
// Mask 1 enables lane 0 only and mask 3 enables both lanes
// Status 'h10 is NV
typedef struct {
  string       name;
  nc_op_e      op;
  fp_fmt_e     fmt;
  logic        vec;
  logic [1:0]  mask;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] exp_res;
  logic [4:0]  exp_status;
} vec_row_t;

vec_row_t rows[$];

task automatic load_table();
  // Sign injection
  rows.push_back('{"sgnj_32", SGNJ, FP32, 0, 1, 'h3F800000, 'hC0200000, 'hBF800000, 'h00});
  rows.push_back('{"sgnjn_32", SGNJN, FP32, 0, 1, 'hBF800000, 'hC0200000, 'h3F800000, 'h00});
  rows.push_back('{"sgnjx_32", SGNJX, FP32, 0, 1, 'hC0200000, 'hBF800000, 'h40200000, 'h00});
  rows.push_back('{"sgnj_16", SGNJ, FP16, 0, 1, 'hABCD3C00, 'h0000C000, 'hFFFFBC00, 'h00});
  rows.push_back('{"sgnjn_16", SGNJN, FP16, 0, 1, 'h12343C00, 'h80004000, 'hFFFFBC00, 'h00});
  rows.push_back('{"sgnjx_16", SGNJX, FP16, 0, 1, 'hFFFFBC00, 'h0000C000, 'hFFFF3C00, 'h00});
  // Min and max
  rows.push_back('{"min_32", MIN, FP32, 0, 1, 'h40000000, 'hC0200000, 'hC0200000, 'h00});
  rows.push_back('{"max_32", MAX, FP32, 0, 1, 'h40000000, 'hC0200000, 'h40000000, 'h00});
  rows.push_back('{"min_zero_32", MIN, FP32, 0, 1, 'h00000000, 'h80000000, 'h80000000, 'h00});
  rows.push_back('{"max_zero_32", MAX, FP32, 0, 1, 'h80000000, 'h00000000, 'h00000000, 'h00});
  rows.push_back('{"min_qnan_32", MIN, FP32, 0, 1, 'h7FC00001, 'h3F800000, 'h3F800000, 'h00});
  rows.push_back('{"max_nan2_32", MAX, FP32, 0, 1, 'h7FC00001, 'h7F800001, 'h7FC00000, 'h10});
  rows.push_back('{"min_snan_32", MIN, FP32, 0, 1, 'h7F800001, 'h40400000, 'h40400000, 'h10});
  rows.push_back('{"max_16", MAX, FP16, 0, 1, 'h00003800, 'h00003C00, 'hFFFF3C00, 'h00});
  rows.push_back('{"min_neg_16", MIN, FP16, 0, 1, 'h0000C000, 'h0000BC00, 'hFFFFC000, 'h00});
  rows.push_back('{"max_nan2_16", MAX, FP16, 0, 1, 'h00007E01, 'h00007C01, 'hFFFF7E00, 'h10});
  // Vector FP16 and scalar fallbacks
  rows.push_back('{"vec_max", MAX, FP16, 1, 3, 'h3C00C000, 'h40008000, 'h40008000, 'h00});
  rows.push_back('{"vec_nv_mask", MIN, FP16, 1, 1, 'h7C013800, 'h3C003C00, 'h3C003800, 'h00});
  rows.push_back('{"vec_nv", MIN, FP16, 1, 3, 'h7C013800, 'h3C003C00, 'h3C003800, 'h10});
  rows.push_back('{"vec_on_32", MIN, FP32, 1, 3, 'h7C010000, 'h3F800000, 'h3F800000, 'h00});
  rows.push_back('{"scalar_16_m3", MIN, FP16, 0, 3, 'h7C013800, 'h3C003C00, 'hFFFF3800, 'h00});
endtask

`endif

/* verif/noncomp_slice_tb.sv */
module noncomp_slice_tb;

  import noncomp_slice_pkg::*;

  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned CLK_PERIOD    = 100;
  localparam int unsigned DRIVE_DLY     = 10;

  `include "noncomp_vectors.svh"

  logic                 clk_i = 1'b0;
  logic                 rst_n_i;
  logic [WIDTH-1:0]     operand_a_i;
  logic [WIDTH-1:0]     operand_b_i;
  nc_op_e               op_i;
  fp_fmt_e              fmt_i;
  logic                 vectorial_i;
  logic [NUM_LANES-1:0] simd_mask_i;
  tag_t                 tag_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic                 flush_i;
  logic [WIDTH-1:0]     result_o;
  status_t              status_o;
  tag_t                 tag_o;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic                 busy_o;

  // Scoreboard holds row indices in input order
  int unsigned expected_q[$];
  logic [31:0] lfsr_state = 32'h4338;
  // Ready mode 0 keeps ready high, 1 stalls at random and 2 holds ready low
  int          ready_mode = 0;
  string       phase_name = "reset";
  int          tests_run = 0;
  int          tests_failed = 0;
  int          other_errors = 0;

  noncomp_slice #(
    .NumPipeRegs (NUM_PIPE_REGS),
    .PipeConfig  (BEFORE)
  ) dut (.*);

  initial begin : clock_gen
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  // ----------------------------------------
  // Random bits
  // ----------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int unsigned rand_bits(input int unsigned n);
    int unsigned val;
    val = 0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
    return val;
  endfunction

  // ----------------------------------------
  // Driver side
  // ----------------------------------------
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
  endtask

  task automatic send_item(input int unsigned idx);
    logic accepted;
    operand_a_i = rows[idx].a;
    operand_b_i = rows[idx].b;
    op_i        = rows[idx].op;
    fmt_i       = rows[idx].fmt;
    vectorial_i = rows[idx].vec;
    simd_mask_i = rows[idx].mask;
    tag_i       = tag_t'(idx);
    in_valid_i  = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
      // Transfer happens on the next edge if ready is high now
      @(negedge clk_i);
      accepted = (in_ready_o === 1'b1);
      if (accepted) begin
        expected_q.push_back(idx);
      end
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (expected_q.size() != 0 || busy_o !== 1'b0) begin
      idle_cycles(1);
    end
  endtask

  initial begin : ready_driver
    logic next_ready;
    forever begin
      @(negedge clk_i);
      case (ready_mode)
        1:       next_ready = (rand_bits(2) != 0);
        2:       next_ready = 1'b0;
        default: next_ready = 1'b1;
      endcase
      @(posedge clk_i);
      #DRIVE_DLY;
      out_ready_i = next_ready;
    end
  end

  // ----------------------------------------
  // Scoreboard
  // ----------------------------------------
  task automatic check_output();
    vec_row_t    row;
    int unsigned idx;
    int          errs;
    errs = 0;
    assert (expected_q.size() > 0) else begin
      $display("Output with tag %h arrived while no item was expected", tag_o);
      other_errors++;
    end
    if (expected_q.size() > 0) begin
      idx = expected_q.pop_front();
      row = rows[idx];
      assert (tag_o === tag_t'(idx)) else begin
        $display("MISMATCH %s tag expected %h actual %h", row.name, tag_t'(idx), tag_o);
        errs++;
      end
      assert (result_o === row.exp_res) else begin
        $display("MISMATCH %s result expected %h actual %h", row.name, row.exp_res, result_o);
        errs++;
      end
      assert (status_o === row.exp_status) else begin
        $display("MISMATCH %s status expected %h actual %h", row.name, row.exp_status,
                 status_o);
        errs++;
      end
      tests_run++;
      if (errs == 0) begin
        $display("%-12s %-14s ok", phase_name, row.name);
      end else begin
        $display("%-12s %-14s FAILED", phase_name, row.name);
        tests_failed++;
      end
    end
  endtask

  initial begin : output_monitor
    forever begin
      @(negedge clk_i);
      if (out_valid_o === 1'b1 && out_ready_i === 1'b1) begin
        check_output();
      end
    end
  end

  task automatic finish_run();
    int unsigned missing;
    missing = expected_q.size();
    if (missing != 0) begin
      $display("%0d expected outputs never arrived", missing);
    end
    $display("Tests run %0d, failed %0d, other errors %0d", tests_run, tests_failed,
             other_errors + missing);
    if (tests_failed == 0 && other_errors == 0 && missing == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin : watchdog
    int unsigned cycles;
    int unsigned limit;
    cycles = 0;
    @(posedge clk_i);
    limit = rows.size() * (NUM_PIPE_REGS + 1) * 8 + 100;
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    other_errors++;
    finish_run();
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main_sequence
    int flush_errs;
    flush_errs  = 0;
    rst_n_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = SGNJ;
    fmt_i       = FP32;
    vectorial_i = 1'b0;
    simd_mask_i = '0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    load_table();
    idle_cycles(2);
    rst_n_i = 1'b1;

    // Back to back with the output always ready
    phase_name = "direct";
    for (int unsigned i = 0; i < rows.size(); i++) begin
      send_item(i);
    end
    wait_drain();

    // Random input gaps and output stalls
    phase_name = "backpressure";
    ready_mode = 1;
    for (int unsigned i = 0; i < rows.size(); i++) begin
      idle_cycles(rand_bits(2));
      send_item(i);
    end
    wait_drain();

    // Two items held at the output are dropped by a flush
    phase_name = "flush";
    ready_mode = 2;
    idle_cycles(2);
    send_item(0);
    send_item(1);
    // Both stages are full with the output stalled
    assert (busy_o === 1'b1 && in_ready_o === 1'b0) else begin
      $display("Two items in flight do not show busy_o high and in_ready_o low");
      flush_errs++;
    end
    flush_i = 1'b1;
    expected_q.delete();
    idle_cycles(1);
    flush_i = 1'b0;
    @(negedge clk_i);
    assert (busy_o === 1'b0 && out_valid_o === 1'b0) else begin
      $display("The pipeline still holds items in the cycle after the flush");
      flush_errs++;
    end
    tests_run++;
    if (flush_errs == 0) begin
      $display("%-12s %-14s ok", phase_name, "drop_inflight");
    end else begin
      $display("%-12s %-14s FAILED", phase_name, "drop_inflight");
      tests_failed++;
    end
    ready_mode = 0;
    idle_cycles(2);
    for (int unsigned i = 2; i < 6; i++) begin
      send_item(i);
    end
    wait_drain();
    finish_run();
  end

endmodule

/* noncomp_slice.f */
+incdir+verif
verilog/noncomp_slice_pkg.sv
verilog/operand_slicer.sv
verilog/pipe_chain.sv
verilog/noncomp_lane.sv
verilog/result_packer.sv
verilog/noncomp_slice.sv
verif/noncomp_slice_asserts.sv
verif/noncomp_slice_tb.sv

/* Bender.yml */
package:
  name: noncomp_slice

sources:
  - files:
      - verilog/noncomp_slice_pkg.sv
      - verilog/operand_slicer.sv
      - verilog/pipe_chain.sv
      - verilog/noncomp_lane.sv
      - verilog/result_packer.sv
      - verilog/noncomp_slice.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/noncomp_slice_asserts.sv
      - verif/noncomp_slice_tb.sv
